// File: Bender.yml
package:
  name: spi_master

sources:
  - files:
      - rtl/spi_pkg.sv
      - rtl/spi_cfg_if.sv
      - rtl/spi_fifo_if.sv
      - rtl/spi_tx_fifo.sv
      - rtl/spi_master_regs.sv
      - rtl/spi_master_io.sv
      - rtl/spi_master.sv
  - target: test
    files:
      - tb/spi_master_tb.sv

// File: rtl/spi_cfg_if.sv
/*
 * mode settings from the register block to the shift engine,
 * and receive status / busy back the other way
 */
`timescale 1ns/10ps
`default_nettype none

interface spi_cfg_if;

   logic               cpol;       // sclk idle level
   logic               cpha;       // sample on trailing edge when set
   logic               lsbfirst;   // shift order
   logic               spi_en;     // engine may start a burst
   spi_pkg::spi_byte_t clkdiv;     // half period is clkdiv+1 clocks

   logic                                 busy;       // engine not idle
   logic [spi_pkg::SPI_RX_BYTES*8-1:0]   rx_data;    // newest byte in 7:0
   logic                                 rx_access;  // one pulse per byte

   // register side
   modport regs (output cpol, cpha, lsbfirst, spi_en, clkdiv,
                 input  busy, rx_data, rx_access);

   // shift engine side
   modport io   (input  cpol, cpha, lsbfirst, spi_en, clkdiv,
                 output busy, rx_data, rx_access);

endinterface

`default_nettype wire

// File: rtl/spi_fifo_if.sv
/*
 * push and pop sides of the transmit byte fifo
 * wr for the register block, rd for the shift engine
 */
`timescale 1ns/10ps
`default_nettype none

interface spi_fifo_if;

   logic               push;       // write strobe, dropped when full
   spi_pkg::spi_byte_t wdata;
   logic               full;
   logic               prog_full;  // fill level at threshold
   logic               pop;        // advance head, dropped when empty
   spi_pkg::spi_byte_t rdata;      // head entry
   logic               empty;

   modport wr   (output push, wdata,
                 input  full, prog_full);

   modport rd   (output pop,
                 input  rdata, empty);

   modport fifo (input  push, wdata, pop,
                 output full, prog_full, rdata, empty);

endinterface

`default_nettype wire

// File: rtl/spi_master.sv
/*
 * spi master top level
 * plain host strobe port and spi pins around regs, tx fifo and shift engine
 */
`timescale 1ns/10ps
`default_nettype none

module spi_master (
   input  logic                          clk,
   input  logic                          nreset,
   // host port
   input  logic                          access,
   input  logic                          write,
   input  logic [spi_pkg::SPI_AW-1:0]    addr,
   input  spi_pkg::spi_word_t            wdata,
   output logic                          rvalid,
   output spi_pkg::spi_word_t            rdata,
   output logic                          wait_req,
   // spi pins
   output logic                          sclk,
   output logic                          mosi,
   output logic                          ss_n,
   input  logic                          miso
);

   spi_cfg_if  cfg_if ();    // mode and rx status
   spi_fifo_if fifo_if ();   // tx byte queue

   // host registers
   spi_master_regs u_regs (
      .clk      (clk),
      .nreset   (nreset),
      .access   (access),
      .write    (write),
      .addr     (addr),
      .wdata    (wdata),
      .rvalid   (rvalid),
      .rdata    (rdata),
      .wait_req (wait_req),
      .cfg      (cfg_if.regs),
      .txq      (fifo_if.wr)
   );

   spi_tx_fifo u_fifo (
      .clk    (clk),
      .nreset (nreset),
      .q      (fifo_if.fifo)
   );

   // shift engine
   spi_master_io u_io (
      .clk    (clk),
      .nreset (nreset),
      .sclk   (sclk),
      .mosi   (mosi),
      .ss_n   (ss_n),
      .miso   (miso),
      .cfg    (cfg_if.io),
      .txq    (fifo_if.rd)
   );

endmodule

`default_nettype wire

// File: rtl/spi_master_io.sv
/*
 * spi shift engine
 * pops bytes from the tx fifo, runs sclk from the divider in any cpol/cpha mode,
 * drives ss_n per burst and collects miso bytes into the rx window
 */
`timescale 1ns/10ps
`default_nettype none

module spi_master_io (
   input  logic     clk,
   input  logic     nreset,
   // spi pins
   output logic     sclk,
   output logic     mosi,
   output logic     ss_n,
   input  logic     miso,
   // config and fifo
   spi_cfg_if.io    cfg,
   spi_fifo_if.rd   txq
);

   spi_pkg::spi_state_e                  state;
   spi_pkg::spi_byte_t                   div_cnt;     // half period counter
   logic [3:0]                           edge_cnt;    // sclk edges done in byte
   logic                                 sclk_ph;     // 0 at idle level
   spi_pkg::spi_byte_t                   shift_tx;
   spi_pkg::spi_byte_t                   shift_rx;
   spi_pkg::spi_byte_t                   rx_next;
   spi_pkg::spi_byte_t                   rx_byte;
   logic [spi_pkg::SPI_RX_BYTES*8-1:0]   rx_window;
   logic                                 half_done;
   logic                                 sample_edge;
   logic                                 last_edge;
   logic                                 start_ok;

   //##################################################
   //# edge bookkeeping
   //##################################################

   assign half_done   = (div_cnt == cfg.clkdiv);
   assign sample_edge = (edge_cnt[0] == cfg.cpha);   // leading for cpha=0
   assign last_edge   = (edge_cnt == 4'd15);
   assign start_ok    = ~txq.empty & cfg.spi_en;

   // miso shifted in according to bit order
   assign rx_next = cfg.lsbfirst ? {miso, shift_rx[7:1]} : {shift_rx[6:0], miso};
   assign rx_byte = sample_edge ? rx_next : shift_rx;   // cpha=1 samples on last edge

   //##################################################
   //# control fsm
   //##################################################

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         state         <= spi_pkg::IDLE;
         div_cnt       <= '0;
         edge_cnt      <= '0;
         sclk_ph       <= 1'b0;
         ss_n          <= 1'b1;
         shift_tx      <= '0;
         cfg.rx_access <= 1'b0;
      end else begin
         cfg.rx_access <= 1'b0;
         case (state)
            spi_pkg::IDLE: begin
               div_cnt  <= '0;
               edge_cnt <= '0;
               sclk_ph  <= 1'b0;
               if (start_ok)
                  state <= spi_pkg::LOAD;
            end
            spi_pkg::LOAD: begin
               shift_tx <= txq.rdata;      // first bit visible before leading edge
               ss_n     <= 1'b0;
               div_cnt  <= '0;
               edge_cnt <= '0;
               state    <= spi_pkg::SHIFT;
            end
            spi_pkg::SHIFT: begin
               if (half_done) begin
                  div_cnt  <= '0;
                  sclk_ph  <= ~sclk_ph;
                  edge_cnt <= edge_cnt + 1'b1;
                  // shift on change edges except the first leading one
                  if (!sample_edge && edge_cnt != 4'd0)
                     shift_tx <= cfg.lsbfirst ? {1'b0, shift_tx[7:1]}
                                              : {shift_tx[6:0], 1'b0};
                  if (last_edge) begin
                     state         <= spi_pkg::GAP;
                     cfg.rx_access <= 1'b1;   // window updated same edge
                  end
               end else begin
                  div_cnt <= div_cnt + 1'b1;
               end
            end
            spi_pkg::GAP: begin
               if (half_done) begin
                  div_cnt <= '0;
                  if (start_ok) begin
                     state <= spi_pkg::LOAD;   // next byte with ss_n held low
                  end else begin
                     ss_n  <= 1'b1;            // close burst
                     state <= spi_pkg::IDLE;
                  end
               end else begin
                  div_cnt <= div_cnt + 1'b1;
               end
            end
            default: state <= spi_pkg::IDLE;
         endcase
      end
   end

   //##################################################
   //# receive path
   //##################################################

   always_ff @(posedge clk) begin
      if (state == spi_pkg::SHIFT && half_done) begin
         if (sample_edge)
            shift_rx <= rx_next;
         if (last_edge)   // older bytes move up
            rx_window <= {rx_window[spi_pkg::SPI_RX_BYTES*8-9:0], rx_byte};
      end
   end

   // outputs
   assign sclk        = sclk_ph ^ cfg.cpol;   // idle level is cpol
   assign mosi        = cfg.lsbfirst ? shift_tx[0] : shift_tx[7];
   assign txq.pop     = (state == spi_pkg::LOAD);   // one pop per byte
   assign cfg.busy    = (state != spi_pkg::IDLE);
   assign cfg.rx_data = rx_window;

endmodule

`default_nettype wire

// File: rtl/spi_master_regs.sv
/*
 * host register block of the spi master
 * decodes strobed accesses into config, clkdiv, status, tx push and rx readback
 */
`timescale 1ns/10ps
`default_nettype none

module spi_master_regs (
   input  logic                          clk,
   input  logic                          nreset,
   // host port
   input  logic                          access,    // one cycle per access
   input  logic                          write,
   input  logic [spi_pkg::SPI_AW-1:0]    addr,
   input  spi_pkg::spi_word_t            wdata,
   output logic                          rvalid,
   output spi_pkg::spi_word_t            rdata,
   output logic                          wait_req,
   // to engine and fifo
   spi_cfg_if.regs                       cfg,
   spi_fifo_if.wr                        txq
);

   spi_pkg::spi_reg_e   reg_sel;
   logic                addr_hit;
   logic                reg_write;
   logic                reg_read;
   logic [7:0]          config_reg;
   spi_pkg::spi_byte_t  clkdiv_reg;
   logic [2:0]          status_reg;
   spi_pkg::spi_byte_t  rx_reg [spi_pkg::SPI_RX_BYTES];
   spi_pkg::spi_word_t  read_mux;

   //##################################################
   //# decode
   //##################################################

   assign reg_sel   = spi_pkg::spi_reg_e'(addr[4:2]);
   assign addr_hit  = (addr[spi_pkg::SPI_AW-1:5] == '0);   // word addr 0..7 only
   assign reg_write = access & write & addr_hit;
   assign reg_read  = access & ~write;

   //##################################################
   //# config
   //##################################################

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         config_reg <= '0;
      else if (reg_write && reg_sel == spi_pkg::CONFIG)
         config_reg <= wdata[7:0];
   end

   assign cfg.spi_en   = ~config_reg[0];   // on by default
   assign cfg.cpol     = config_reg[2];
   assign cfg.cpha     = config_reg[3];
   assign cfg.lsbfirst = config_reg[4];

   // clock divider
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         clkdiv_reg <= 8'(spi_pkg::SPI_CLKDIV_RESET);
      else if (reg_write && reg_sel == spi_pkg::CLKDIV)
         clkdiv_reg <= wdata[7:0];
   end

   assign cfg.clkdiv = clkdiv_reg;

   //##################################################
   //# status
   //##################################################

   // bit0 sticky rx, bit1 busy, bit2 prog_full
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         status_reg <= '0;
      end else begin
         status_reg[2] <= txq.prog_full;
         status_reg[1] <= cfg.busy;
         if (reg_write && reg_sel == spi_pkg::STATUS)
            status_reg[0] <= 1'b0;                  // any write clears
         else if (cfg.rx_access)
            status_reg[0] <= 1'b1;
      end
   end

   // snapshot of the rx window per received byte
   always_ff @(posedge clk) begin
      if (cfg.rx_access)
         for (int i = 0; i < spi_pkg::SPI_RX_BYTES; i++)
            rx_reg[i] <= cfg.rx_data[i*8 +: 8];
   end

   //##################################################
   //# tx push and back-pressure
   //##################################################

   assign txq.push  = reg_write && (reg_sel == spi_pkg::TX);
   assign txq.wdata = wdata[7:0];
   assign wait_req  = txq.full;   // level, host holds off tx writes

   //##################################################
   //# readback
   //##################################################

   always_comb begin
      read_mux = '0;
      if (addr_hit) begin
         case (reg_sel)
            spi_pkg::CONFIG: read_mux = {24'b0, config_reg};
            spi_pkg::STATUS: read_mux = {29'b0, status_reg};
            spi_pkg::CLKDIV: read_mux = {24'b0, clkdiv_reg};
            spi_pkg::RX_LO:  read_mux = {rx_reg[3], rx_reg[2], rx_reg[1], rx_reg[0]};
            spi_pkg::RX_HI:  read_mux = {rx_reg[7], rx_reg[6], rx_reg[5], rx_reg[4]};
            default:         read_mux = '0;   // tx reads as zero
         endcase
      end
   end

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         rvalid <= 1'b0;
      else
         rvalid <= reg_read;   // one cycle after access
   end

   always_ff @(posedge clk) begin
      if (reg_read)
         rdata <= read_mux;
   end

endmodule

`default_nettype wire

// File: rtl/spi_pkg.sv
/*
 * shared definitions for the spi master
 * register map, engine states, data types and sizing constants
 */
`default_nettype none

package spi_pkg;

   //##################################################
   //# sizing
   //##################################################
   localparam int SPI_AW           = 8;                       // host byte address width
   localparam int SPI_FIFO_DEPTH   = 8;                       // tx fifo entries
   localparam int SPI_FIFO_AW      = $clog2(SPI_FIFO_DEPTH);  // fifo pointer width
   localparam int SPI_FIFO_PROG    = 4;                       // prog_full threshold
   localparam int SPI_CLKDIV_RESET = 1;                       // divider after reset
   localparam int SPI_RX_BYTES     = 8;                       // bytes in rx window

   typedef logic [7:0]  spi_byte_t;   // one transfer byte
   typedef logic [31:0] spi_word_t;   // one host word

   // word addresses, matched against addr[7:2]
   typedef enum logic [2:0] {
      CONFIG = 3'd0,
      STATUS = 3'd1,
      CLKDIV = 3'd2,
      TX     = 3'd3,
      RX_LO  = 3'd4,
      RX_HI  = 3'd5
   } spi_reg_e;

   // shift engine states
   typedef enum logic [1:0] {
      IDLE,    // nothing queued or disabled
      LOAD,    // pop byte, drop ss_n
      SHIFT,   // clocking bits
      GAP      // half period after a byte
   } spi_state_e;

endpackage

`default_nettype wire

// File: rtl/spi_tx_fifo.sv
/*
 * transmit byte fifo between the register block and the shift engine
 * circular buffer with full, empty and programmable-full flags
 */
`timescale 1ns/10ps
`default_nettype none

module spi_tx_fifo (
   input  logic     clk,
   input  logic     nreset,
   spi_fifo_if.fifo q
);

   spi_pkg::spi_byte_t                 mem [spi_pkg::SPI_FIFO_DEPTH];
   logic [spi_pkg::SPI_FIFO_AW-1:0]    wr_ptr;
   logic [spi_pkg::SPI_FIFO_AW-1:0]    rd_ptr;
   logic [spi_pkg::SPI_FIFO_AW:0]      count;    // one extra bit for full
   logic                               do_push;
   logic                               do_pop;

   assign do_push = q.push & ~q.full;    // push dropped when full
   assign do_pop  = q.pop  & ~q.empty;   // pop dropped when empty

   //##################################################
   //# pointers and fill count
   //##################################################

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two, wraps
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;     // both or neither
         endcase
      end
   end

   // storage
   always_ff @(posedge clk) begin
      if (do_push)
         mem[wr_ptr] <= q.wdata;
   end

   //##################################################
   //# flags
   //##################################################

   assign q.rdata     = mem[rd_ptr];   // head, valid while not empty
   assign q.empty     = (count == 0);
   assign q.full      = (count == spi_pkg::SPI_FIFO_DEPTH);
   assign q.prog_full = (count >= spi_pkg::SPI_FIFO_PROG);

endmodule

`default_nettype wire

// File: src.f
rtl/spi_pkg.sv
rtl/spi_cfg_if.sv
rtl/spi_fifo_if.sv
rtl/spi_tx_fifo.sv
rtl/spi_master_regs.sv
rtl/spi_master_io.sv
rtl/spi_master.sv
tb/spi_master_tb.sv

// File: tb/spi_master_tb.sv
/*
 * testbench for the spi master
 * applies a table of register accesses and byte transfers, with a spi slave model on the pins
 */
`timescale 1ns/10ps
`default_nettype none

module spi_master_tb;

   localparam int WAIT_LIMIT = 2000;     // cycles or polls per handshake wait
   localparam int XFER_LIMIT = 50000;    // cycles for a whole queue to drain

   typedef enum logic [2:0] {OP_RD, OP_WR, OP_TX, OP_WIN, OP_FLOOD, OP_HOLD} op_e;

   typedef struct {
      op_e                           op;
      logic [spi_pkg::SPI_AW-1:0]    addr;
      spi_pkg::spi_word_t            data;
      spi_pkg::spi_word_t            exp;
      string                         name;
   } row_t;

   logic                          clk = 1'b0;
   logic                          nreset;
   logic                          access;
   logic                          write;
   logic [spi_pkg::SPI_AW-1:0]    addr;
   spi_pkg::spi_word_t            wdata;
   logic                          rvalid;
   spi_pkg::spi_word_t            rdata;
   logic                          wait_req;
   logic                          sclk;
   logic                          mosi;
   logic                          ss_n;
   logic                          miso = 1'b0;

   row_t                 table_q [$];
   int                   errors = 0;
   int                   checks = 0;
   // slave model state
   logic [15:0]          lfsr = 16'd3503;
   spi_pkg::spi_byte_t   cur_byte;          // byte going out on miso
   spi_pkg::spi_byte_t   mosi_acc;
   logic                 loaded = 1'b0;
   logic                 sclk_q;
   logic                 ss_q;
   int                   edge_idx = 0;      // sclk edges seen in this byte
   logic                 mode_cpol = 1'b0;
   logic                 mode_cpha = 1'b0;
   logic                 mode_lsb = 1'b0;
   spi_pkg::spi_byte_t   mosi_q [$];        // bytes seen by the slave
   spi_pkg::spi_byte_t   tx_exp [$];        // bytes pushed, in order
   spi_pkg::spi_byte_t   slave_hist [$];    // every miso byte sent

   always #5 clk = ~clk;

   spi_master UUT (
      .clk      (clk),
      .nreset   (nreset),
      .access   (access),
      .write    (write),
      .addr     (addr),
      .wdata    (wdata),
      .rvalid   (rvalid),
      .rdata    (rdata),
      .wait_req (wait_req),
      .sclk     (sclk),
      .mosi     (mosi),
      .ss_n     (ss_n),
      .miso     (miso)
   );

   //##################################################
   //# spi slave model
   //##################################################

   // galois lfsr, taps 16,14,13,11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   function automatic int bit_pos(input int k);
      return mode_lsb ? k : 7 - k;   // k-th bit on the wire
   endfunction

   task automatic load_slave_byte();
      for (int i = 0; i < 8; i++) begin
         lfsr        = lfsr_step(lfsr);   // one step per bit
         cur_byte[i] = lfsr[0];
      end
      loaded = 1'b1;
   endtask

   // edges seen one clk late, sclk and mosi hold for at least two clks
   always @(posedge clk) begin
      sclk_q <= sclk;
      ss_q   <= ss_n;
      if (ss_n) begin
         edge_idx = 0;
      end else if (ss_q) begin                     // burst start
         if (!loaded)
            load_slave_byte();
         miso <= cur_byte[bit_pos(0)];
         edge_idx = 0;
      end else if (sclk !== sclk_q) begin
         if (edge_idx[0] == mode_cpha) begin       // sample edge
            mosi_acc[bit_pos(edge_idx / 2)] = mosi;
         end else if (mode_cpha) begin             // leading change edge
            if (!loaded)
               load_slave_byte();
            miso <= cur_byte[bit_pos(edge_idx / 2)];
         end else if (edge_idx < 15) begin         // trailing change edge
            miso <= cur_byte[bit_pos(edge_idx / 2 + 1)];
         end
         if (edge_idx == 15) begin
            mosi_q.push_back(mosi_acc);
            slave_hist.push_back(cur_byte);
            loaded   = 1'b0;
            edge_idx = 0;
            if (!mode_cpha) begin                  // next first bit set up early
               load_slave_byte();
               miso <= cur_byte[bit_pos(0)];
            end
         end else begin
            edge_idx++;
         end
      end
   end

   //##################################################
   //# checks and reporting
   //##################################################

   task automatic check_word(input string name, input spi_pkg::spi_word_t exp,
                             input spi_pkg::spi_word_t act);
      checks++;
      if (act !== exp) begin
         $display("[FAIL] %s expected %08h actual %08h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_byte(input string name, input spi_pkg::spi_byte_t exp,
                             input spi_pkg::spi_byte_t act);
      checks++;
      if (act !== exp) begin
         $display("[FAIL] %s expected %02h actual %02h", name, exp, act);
         errors++;
      end
   endtask

   task automatic print_summary();
      $display("checks %0d errors %0d", checks, errors);
   endtask

   task automatic abort_run(input string what);
      $display("timeout while waiting for %s", what);
      errors++;
      print_summary();
      $display("=== FAIL ===");
      $finish;
   endtask

   //##################################################
   //# host port
   //##################################################

   function automatic logic [spi_pkg::SPI_AW-1:0] reg_addr(input spi_pkg::spi_reg_e r);
      return {3'b000, r, 2'b00};
   endfunction

   task automatic host_write(input logic [spi_pkg::SPI_AW-1:0] a,
                             input spi_pkg::spi_word_t d);
      @(posedge clk);
      access <= 1'b1;
      write  <= 1'b1;
      addr   <= a;
      wdata  <= d;
      @(posedge clk);
      access <= 1'b0;
      write  <= 1'b0;
      if (a == reg_addr(spi_pkg::CONFIG)) begin   // slave follows the mode
         mode_cpol = d[2];
         mode_cpha = d[3];
         mode_lsb  = d[4];
      end
   endtask

   task automatic host_read(input logic [spi_pkg::SPI_AW-1:0] a,
                            output spi_pkg::spi_word_t d);
      @(posedge clk);
      access <= 1'b1;
      write  <= 1'b0;
      addr   <= a;
      @(posedge clk);
      access <= 1'b0;
      @(negedge clk);                                // one cycle after access
      checks++;
      if (rvalid !== 1'b1) begin
         $display("rvalid did not pulse one cycle after a read of address %02h", a);
         errors++;
      end
      d = rdata;
   endtask

   // tx write once wait_req is low
   task automatic push_byte(input spi_pkg::spi_byte_t b);
      int n;
      n = 0;
      @(negedge clk);
      while (wait_req !== 1'b0) begin
         if (n == WAIT_LIMIT)
            abort_run("wait_req to fall");
         n++;
         @(negedge clk);
      end
      host_write(reg_addr(spi_pkg::TX), {24'b0, b});
      tx_exp.push_back(b);
   endtask

   // all queued bytes at the slave, then poll until busy clears
   task automatic drain(input string name, output spi_pkg::spi_word_t st);
      int n;
      n = 0;
      while (mosi_q.size() < tx_exp.size()) begin
         if (n == XFER_LIMIT)
            abort_run("the slave to receive all queued bytes");
         n++;
         @(negedge clk);
      end
      n = 0;
      host_read(reg_addr(spi_pkg::STATUS), st);
      while (st[1] !== 1'b0) begin
         if (n == WAIT_LIMIT)
            abort_run("busy to clear");
         n++;
         host_read(reg_addr(spi_pkg::STATUS), st);
      end
      while (tx_exp.size() > 0)
         check_byte({name, "_mosi"}, tx_exp.pop_front(), mosi_q.pop_front());
      if (mosi_q.size() != 0) begin
         $display("slave received %0d more bytes than were queued", mosi_q.size());
         errors++;
         mosi_q.delete();
      end
   endtask

   //##################################################
   //# stimulus table
   //##################################################

   task automatic add_row(input op_e op, input spi_pkg::spi_reg_e r,
                          input spi_pkg::spi_word_t d, input spi_pkg::spi_word_t e,
                          input string name);
      table_q.push_back('{op, reg_addr(r), d, e, name});
   endtask

   task automatic build_table();
      spi_pkg::spi_byte_t b;
      add_row(OP_RD, spi_pkg::CONFIG, 0, 0, "reset_config");
      add_row(OP_RD, spi_pkg::CLKDIV, 0, spi_pkg::SPI_CLKDIV_RESET, "reset_clkdiv");
      add_row(OP_RD, spi_pkg::STATUS, 0, 0, "reset_status");
      add_row(OP_WR, spi_pkg::CONFIG, 32'hffff_ff1c, 0, "config_write");
      add_row(OP_RD, spi_pkg::CONFIG, 0, 32'h1c, "config_readback");
      add_row(OP_WR, spi_pkg::CLKDIV, 32'h0000_1207, 0, "clkdiv_write");
      add_row(OP_RD, spi_pkg::CLKDIV, 0, 32'h07, "clkdiv_readback");
      add_row(OP_WR, spi_pkg::CLKDIV, 2, 0, "clkdiv_set");
      // m = {lsbfirst, cpha, cpol}
      for (int m = 0; m < 8; m++) begin
         b = 8'h4B + 8'(m * 29);
         add_row(OP_WR, spi_pkg::CONFIG, 32'(m << 2), 0, "mode_set");
         add_row(OP_TX, spi_pkg::TX, {24'b0, b}, 0,
                 $sformatf("tx_cpol%0d_cpha%0d_lsb%0d", m & 1, (m >> 1) & 1, m >> 2));
      end
      add_row(OP_WR, spi_pkg::CONFIG, 0, 0, "mode_default");
      add_row(OP_WIN, spi_pkg::TX, 32'h10, 0, "rx_window");
      add_row(OP_WR, spi_pkg::CLKDIV, 40, 0, "clkdiv_slow");
      add_row(OP_FLOOD, spi_pkg::TX, 32'h80, 0, "backpressure");
      add_row(OP_WR, spi_pkg::CLKDIV, 2, 0, "clkdiv_fast");
      add_row(OP_WR, spi_pkg::STATUS, 0, 0, "status_write");
      add_row(OP_RD, spi_pkg::STATUS, 0, 0, "sticky_clear");
      add_row(OP_HOLD, spi_pkg::TX, 32'hc3, 0, "disabled_hold");
   endtask

   task automatic run_row(input row_t r);
      spi_pkg::spi_word_t w;
      spi_pkg::spi_word_t hi;
      int                 n;
      case (r.op)
         OP_WR: host_write(r.addr, r.data);
         OP_RD: begin
            host_read(r.addr, w);
            check_word(r.name, r.exp, w);
         end
         OP_TX: begin
            host_write(reg_addr(spi_pkg::STATUS), '0);   // drop sticky rx first
            push_byte(r.data[7:0]);
            drain(r.name, w);
            check_word({r.name, "_sticky"}, 32'h1, w & 32'h1);
            host_read(reg_addr(spi_pkg::RX_LO), w);
            check_byte({r.name, "_miso"}, slave_hist[$], w[7:0]);
         end
         OP_WIN: begin
            for (int i = 0; i < spi_pkg::SPI_RX_BYTES; i++)
               push_byte(r.data[7:0] + 8'(i));
            drain(r.name, w);
            n = slave_hist.size();
            host_read(reg_addr(spi_pkg::RX_HI), hi);
            host_read(reg_addr(spi_pkg::RX_LO), w);
            // oldest byte lands in the top of rx_hi
            check_word({r.name, "_hi"}, {slave_hist[n-8], slave_hist[n-7],
                                         slave_hist[n-6], slave_hist[n-5]}, hi);
            check_word({r.name, "_lo"}, {slave_hist[n-4], slave_hist[n-3],
                                         slave_hist[n-2], slave_hist[n-1]}, w);
         end
         OP_FLOOD: begin
            for (int i = 0; i < 5; i++)
               push_byte(r.data[7:0] + 8'(i));
            host_read(reg_addr(spi_pkg::STATUS), w);
            check_word({r.name, "_prog_full"}, 32'h4, w & 32'h4);
            n = 5;
            @(negedge clk);
            while (wait_req !== 1'b1 && n < 3 * spi_pkg::SPI_FIFO_DEPTH) begin
               push_byte(r.data[7:0] + 8'(n));
               n++;
               @(negedge clk);
            end
            checks++;
            if (wait_req !== 1'b1) begin
               $display("wait_req never rose while the tx fifo was filled");
               errors++;
            end
            push_byte(r.data[7:0] + 8'(n));       // waits out the back-pressure
            push_byte(r.data[7:0] + 8'(n + 1));
            drain(r.name, w);
         end
         OP_HOLD: begin
            host_write(reg_addr(spi_pkg::CONFIG), 32'h1);   // engine off
            push_byte(r.data[7:0]);
            checks++;
            for (int i = 0; i < 200; i++) begin
               @(negedge clk);
               if (ss_n !== 1'b1 || sclk !== mode_cpol) begin
                  $display("spi bus became active while the engine was disabled");
                  errors++;
                  break;
               end
            end
            host_write(reg_addr(spi_pkg::CONFIG), '0);      // queued byte goes now
            drain(r.name, w);
         end
         default: ;
      endcase
   endtask

   //##################################################
   //# main sequence
   //##################################################

   initial begin
      nreset = 1'b0;
      access = 1'b0;
      write  = 1'b0;
      addr   = '0;
      wdata  = '0;
      build_table();
      repeat (5) @(posedge clk);
      nreset <= 1'b1;
      repeat (2) @(posedge clk);
      foreach (table_q[i])
         run_row(table_q[i]);
      repeat (4) @(posedge clk);
      print_summary();
      if (errors == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

`default_nettype wire
